//--- hdl/dec_pkg.sv
package dec_pkg;

    localparam int ROB_TAG_W = 3;

    typedef logic [31:0]          word_t;
    typedef logic [4:0]           reg_idx_t;
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;
    typedef logic [4:0]           rs_type_t;   // {is_branch, alt, funct3}
    typedef logic [3:0]           lsb_type_t;  // {is_store, funct3}
    typedef logic [11:0]          imm12_t;

    // Base opcode groups, low bits always 2'b11
    typedef enum logic [6:0] {
        OP_NONE    = 7'b0000000,
        OP_ARITH_R = 7'b0110011,
        OP_ARITH_I = 7'b0010011,
        OP_LOAD    = 7'b0000011,
        OP_STORE   = 7'b0100011,
        OP_BRANCH  = 7'b1100011,
        OP_JAL     = 7'b1101111,
        OP_JALR    = 7'b1100111,
        OP_AUIPC   = 7'b0010111,
        OP_LUI     = 7'b0110111
    } opcode_e;

    typedef enum logic [1:0] {
        ROB_RG = 2'd0,  // Register result
        ROB_ST = 2'd1,
        ROB_BR = 2'd2
    } rob_kind_e;

    typedef struct packed {
        word_t    r1;
        word_t    r2;
        rob_tag_t dep1;
        rob_tag_t dep2;
        logic     has_dep1;
        logic     has_dep2;
    } operand_pair_t;

    typedef struct packed {
        logic      valid;
        logic      ready;
        rob_kind_e kind;
        word_t     value;  // Result, or branch target
        reg_idx_t  rd;
    } rob_entry_t;

    typedef struct packed {
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        logic      use_rs1;
        logic      use_rs2;
        logic      use_rd;
        logic      need_rs;
        logic      need_lsb;
        logic      is_jalr;
        rs_type_t  rs_type;
        lsb_type_t lsb_type;
        imm12_t    offset;
        word_t     imm_r2;
        logic      use_imm;   // imm_r2 replaces r2
        logic      rob_ready;
        word_t     rob_value;
        opcode_e   kind;
    } decoded_t;

endpackage

//--- hdl/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
    input  dec_pkg::word_t    inst,
    output dec_pkg::reg_idx_t rs1,
    output dec_pkg::reg_idx_t rs2,
    output dec_pkg::reg_idx_t rd,
    output logic [2:0]        funct3,
    output logic              alt_bit,
    output dec_pkg::word_t    imm_i,
    output dec_pkg::word_t    imm_s,
    output dec_pkg::word_t    imm_b,
    output dec_pkg::word_t    imm_u,
    output dec_pkg::word_t    imm_j
);

    logic sign;

    assign sign = inst[31];

    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct3 = inst[14:12];
    assign alt_bit = inst[30];  // funct7[5], also imm[10] of SRAI

    assign imm_i = {{20{sign}}, inst[31:20]};

    assign imm_s = {{20{sign}}, inst[31:25], inst[11:7]};

    assign imm_b = {
        {19{sign}},
        inst[31],
        inst[7],
        inst[30:25],
        inst[11:8],
        1'b0
    };

    assign imm_u = {inst[31:12], 12'b0};

    assign imm_j = {
        {11{sign}},
        inst[31],
        inst[19:12],
        inst[20],
        inst[30:21],
        1'b0
    };

endmodule

//--- hdl/op_classify.sv
`timescale 1ns/1ps

module op_classify (
    input  dec_pkg::word_t    inst,
    input  dec_pkg::word_t    inst_addr,
    input  dec_pkg::word_t    r1_val,
    output dec_pkg::decoded_t dec,
    output dec_pkg::word_t    next_pc,
    output dec_pkg::reg_idx_t rf_idx1,
    output dec_pkg::reg_idx_t rf_idx2
);

    dec_pkg::reg_idx_t rs1;
    dec_pkg::reg_idx_t rs2;
    dec_pkg::reg_idx_t rd;
    logic [2:0]        funct3;
    logic              alt_bit;
    dec_pkg::word_t    imm_i;
    dec_pkg::word_t    imm_s;
    dec_pkg::word_t    imm_b;
    dec_pkg::word_t    imm_u;
    dec_pkg::word_t    imm_j;

    dec_pkg::opcode_e  opcode;
    logic              legal;
    logic              is_arith_r;
    logic              is_arith_i;
    logic              is_load;
    logic              is_store;
    logic              is_branch;
    logic              is_jal;
    logic              is_jalr;
    logic              is_auipc;
    logic              is_lui;
    logic              is_shift;
    dec_pkg::word_t    seq_pc;

    imm_gen u_imm_gen (
        .inst    (inst),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .funct3  (funct3),
        .alt_bit (alt_bit),
        .imm_i   (imm_i),
        .imm_s   (imm_s),
        .imm_b   (imm_b),
        .imm_u   (imm_u),
        .imm_j   (imm_j)
    );

    always_comb begin
        opcode = dec_pkg::OP_NONE;
        if (inst[1:0] == 2'b11) begin  // Compressed encodings become bubbles
            case (inst[6:0])
                dec_pkg::OP_ARITH_R, dec_pkg::OP_ARITH_I, dec_pkg::OP_LOAD,
                dec_pkg::OP_STORE, dec_pkg::OP_BRANCH, dec_pkg::OP_JAL,
                dec_pkg::OP_JALR, dec_pkg::OP_AUIPC, dec_pkg::OP_LUI:
                    opcode = dec_pkg::opcode_e'(inst[6:0]);
                default: opcode = dec_pkg::OP_NONE;
            endcase
        end
    end

    assign legal      = opcode != dec_pkg::OP_NONE;
    assign is_arith_r = opcode == dec_pkg::OP_ARITH_R;
    assign is_arith_i = opcode == dec_pkg::OP_ARITH_I;
    assign is_load    = opcode == dec_pkg::OP_LOAD;
    assign is_store   = opcode == dec_pkg::OP_STORE;
    assign is_branch  = opcode == dec_pkg::OP_BRANCH;
    assign is_jal     = opcode == dec_pkg::OP_JAL;
    assign is_jalr    = opcode == dec_pkg::OP_JALR;
    assign is_auipc   = opcode == dec_pkg::OP_AUIPC;
    assign is_lui     = opcode == dec_pkg::OP_LUI;
    assign is_shift   = funct3 == 3'b001 || funct3 == 3'b101;  // SLLI, SRLI, SRAI

    assign seq_pc = inst_addr + 32'd4;

    always_comb begin
        dec = '0;
        dec.kind     = opcode;
        dec.rs1      = legal ? rs1 : '0;
        dec.rs2      = legal ? rs2 : '0;
        dec.rd       = legal ? rd : '0;
        dec.use_rs1  = is_arith_r || is_arith_i || is_load || is_store || is_branch || is_jalr;
        dec.use_rs2  = is_arith_r || is_store || is_branch;
        dec.use_rd   = is_arith_r || is_arith_i || is_load || is_jalr || is_jal
                       || is_lui || is_auipc;
        dec.need_rs  = is_arith_r || is_arith_i || is_branch;
        dec.need_lsb = is_load || is_store;
        dec.is_jalr  = is_jalr;
        dec.rs_type  = {is_branch,
                        alt_bit && (is_arith_r || (is_arith_i && funct3 == 3'b101)),
                        funct3};
        dec.lsb_type = {is_store, funct3};
        dec.offset   = is_load ? imm_i[11:0] : imm_s[11:0];
        dec.imm_r2   = is_shift ? {27'b0, inst[24:20]} : imm_i;
        dec.use_imm  = is_arith_i;
        dec.rob_ready = is_lui || is_auipc || is_jal || is_jalr || is_store;

        if (is_lui)
            dec.rob_value = imm_u;
        else if (is_auipc)
            dec.rob_value = inst_addr + imm_u;
        else if (is_jal || is_jalr)
            dec.rob_value = seq_pc;  // Link address
        else if (is_branch)
            dec.rob_value = inst_addr + imm_b;
        else
            dec.rob_value = '0;
    end

    assign next_pc = is_jalr ? r1_val + imm_i :
                     is_jal  ? inst_addr + imm_j : seq_pc;

    assign rf_idx1 = dec.rs1;
    assign rf_idx2 = dec.rs2;

endmodule

//--- hdl/operand_resolve.sv
`timescale 1ns/1ps

module operand_resolve (
    input  dec_pkg::word_t    rf_val1,
    input  dec_pkg::word_t    rf_val2,
    input  logic              rf_has_dep1,
    input  logic              rf_has_dep2,
    input  dec_pkg::rob_tag_t rf_dep1,
    input  dec_pkg::rob_tag_t rf_dep2,
    input  logic              query_ready1,
    input  logic              query_ready2,
    input  dec_pkg::word_t    query_val1,
    input  dec_pkg::word_t    query_val2,
    output dec_pkg::rob_tag_t query_idx1,
    output dec_pkg::rob_tag_t query_idx2,
    output dec_pkg::word_t    r1_val,
    output dec_pkg::word_t    r2_val,
    output logic              pending1,
    output logic              pending2
);

    // Ask the ROB about whichever entry the register file points at
    assign query_idx1 = rf_dep1;
    assign query_idx2 = rf_dep2;

    assign r1_val = !rf_has_dep1 ? rf_val1 :
                    query_ready1 ? query_val1 : '0;  // Forward from ROB
    assign r2_val = !rf_has_dep2 ? rf_val2 :
                    query_ready2 ? query_val2 : '0;

    assign pending1 = rf_has_dep1 && !query_ready1;
    assign pending2 = rf_has_dep2 && !query_ready2;

endmodule

//--- hdl/dispatch_reg.sv
`timescale 1ns/1ps

module dispatch_reg (
    input  logic                  clk_in,
    input  logic                  rst_n,
    input  logic                  rdy_in,
    input  logic                  rob_clear,
    input  logic                  inst_valid,
    input  dec_pkg::word_t        inst_addr,
    input  dec_pkg::decoded_t     dec,
    input  dec_pkg::word_t        r1_val,
    input  dec_pkg::word_t        r2_val,
    input  logic                  pending1,
    input  logic                  pending2,
    input  dec_pkg::rob_tag_t     dep1,
    input  dec_pkg::rob_tag_t     dep2,
    input  logic                  rob_full,
    input  logic                  rs_full,
    input  logic                  lsb_full,
    output logic                  f_ok,
    output dec_pkg::rob_entry_t   rob_entry,
    output logic                  rs_valid,
    output dec_pkg::rs_type_t     rs_type,
    output logic                  lsb_valid,
    output dec_pkg::lsb_type_t    lsb_type,
    output dec_pkg::imm12_t       lsb_offset,
    output dec_pkg::operand_pair_t ops,
    output dec_pkg::reg_idx_t     rf_set_idx
);

    dec_pkg::word_t    last_addr;
    logic              new_inst;
    logic              units_free;
    dec_pkg::rob_kind_e kind;
    dec_pkg::reg_idx_t dest;

    assign new_inst = inst_valid && dec.kind != dec_pkg::OP_NONE
                      && inst_addr != last_addr;  // Same fetch address never issues twice

    assign units_free = !rob_full
                        && (!dec.need_rs || !rs_full)
                        && (!dec.need_lsb || !lsb_full)
                        && !(dec.is_jalr && pending1);  // JALR target needs its base

    assign f_ok = new_inst && units_free;

    assign kind = dec.kind == dec_pkg::OP_STORE  ? dec_pkg::ROB_ST :
                  dec.kind == dec_pkg::OP_BRANCH ? dec_pkg::ROB_BR : dec_pkg::ROB_RG;

    assign dest = dec.use_rd ? dec.rd : '0;

    always_ff @(posedge clk_in) begin
        if (!rst_n || rob_clear) begin
            rob_entry  <= '0;
            rs_valid   <= 1'b0;
            rs_type    <= '0;
            lsb_valid  <= 1'b0;
            lsb_type   <= '0;
            lsb_offset <= '0;
            ops        <= '0;
            rf_set_idx <= '0;
            last_addr  <= '1;
        end else if (rdy_in) begin
            if (f_ok) begin
                last_addr <= inst_addr;

                rob_entry.valid <= 1'b1;  // Every accepted instruction
                rob_entry.ready <= dec.rob_ready;
                rob_entry.kind  <= kind;
                rob_entry.value <= dec.rob_value;
                rob_entry.rd    <= dest;

                rs_valid   <= dec.need_rs;
                rs_type    <= dec.rs_type;
                lsb_valid  <= dec.need_lsb;
                lsb_type   <= dec.lsb_type;
                lsb_offset <= dec.offset;

                ops.r1       <= r1_val;
                ops.r2       <= dec.use_imm ? dec.imm_r2 : r2_val;
                ops.dep1     <= dep1;
                ops.dep2     <= dep2;
                ops.has_dep1 <= dec.use_rs1 && pending1;
                ops.has_dep2 <= dec.use_rs2 && pending2;

                rf_set_idx <= dest;
            end else begin
                rob_entry.valid <= 1'b0;
                rs_valid        <= 1'b0;
                lsb_valid       <= 1'b0;
                rf_set_idx      <= '0;
            end
        end
    end

endmodule

//--- hdl/decoder_top.sv
`timescale 1ns/1ps

module decoder_top (
    input  logic                   clk_in,
    input  logic                   rst_n,
    input  logic                   rdy_in,
    input  logic                   rob_clear,
    input  logic                   inst_valid,
    input  dec_pkg::word_t         inst_addr,
    input  dec_pkg::word_t         inst_data,
    output dec_pkg::word_t         f_next_pc,
    output logic                   f_ok,
    output dec_pkg::reg_idx_t      rf_get_idx1,
    output dec_pkg::reg_idx_t      rf_get_idx2,
    input  dec_pkg::word_t         rf_get_val1,
    input  dec_pkg::word_t         rf_get_val2,
    input  logic                   rf_has_dep1,
    input  logic                   rf_has_dep2,
    input  dec_pkg::rob_tag_t      rf_get_dep1,
    input  dec_pkg::rob_tag_t      rf_get_dep2,
    output dec_pkg::reg_idx_t      rf_set_idx,
    output dec_pkg::rob_tag_t      rf_set_dep,
    output dec_pkg::rob_tag_t      query_rob_idx1,
    output dec_pkg::rob_tag_t      query_rob_idx2,
    input  logic                   query_ready1,
    input  logic                   query_ready2,
    input  dec_pkg::word_t         query_value1,
    input  dec_pkg::word_t         query_value2,
    input  dec_pkg::rob_tag_t      rob_idx_tail,
    input  logic                   rob_full,
    output dec_pkg::rob_entry_t    rob_entry,
    input  logic                   rs_full,
    output logic                   rs_valid,
    output dec_pkg::rs_type_t      rs_type,
    output dec_pkg::rob_tag_t      rs_rob_idx,
    input  logic                   lsb_full,
    output logic                   lsb_valid,
    output dec_pkg::lsb_type_t     lsb_type,
    output dec_pkg::imm12_t        lsb_offset,
    output dec_pkg::rob_tag_t      lsb_rob_idx,
    output dec_pkg::operand_pair_t ops
);

    dec_pkg::decoded_t dec;
    dec_pkg::word_t    r1_val;
    dec_pkg::word_t    r2_val;
    logic              pending1;
    logic              pending2;

    op_classify u_op_classify (
        .inst      (inst_data),
        .inst_addr (inst_addr),
        .r1_val    (r1_val),
        .dec       (dec),
        .next_pc   (f_next_pc),
        .rf_idx1   (rf_get_idx1),
        .rf_idx2   (rf_get_idx2)
    );

    operand_resolve u_operand_resolve (
        .rf_val1      (rf_get_val1),
        .rf_val2      (rf_get_val2),
        .rf_has_dep1  (rf_has_dep1),
        .rf_has_dep2  (rf_has_dep2),
        .rf_dep1      (rf_get_dep1),
        .rf_dep2      (rf_get_dep2),
        .query_ready1 (query_ready1),
        .query_ready2 (query_ready2),
        .query_val1   (query_value1),
        .query_val2   (query_value2),
        .query_idx1   (query_rob_idx1),
        .query_idx2   (query_rob_idx2),
        .r1_val       (r1_val),
        .r2_val       (r2_val),
        .pending1     (pending1),
        .pending2     (pending2)
    );

    dispatch_reg u_dispatch_reg (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .rdy_in     (rdy_in),
        .rob_clear  (rob_clear),
        .inst_valid (inst_valid),
        .inst_addr  (inst_addr),
        .dec        (dec),
        .r1_val     (r1_val),
        .r2_val     (r2_val),
        .pending1   (pending1),
        .pending2   (pending2),
        .dep1       (rf_get_dep1),
        .dep2       (rf_get_dep2),
        .rob_full   (rob_full),
        .rs_full    (rs_full),
        .lsb_full   (lsb_full),
        .f_ok       (f_ok),
        .rob_entry  (rob_entry),
        .rs_valid   (rs_valid),
        .rs_type    (rs_type),
        .lsb_valid  (lsb_valid),
        .lsb_type   (lsb_type),
        .lsb_offset (lsb_offset),
        .ops        (ops),
        .rf_set_idx (rf_set_idx)
    );

    // Tail slot tag goes straight to every consumer
    assign rs_rob_idx  = rob_idx_tail;
    assign lsb_rob_idx = rob_idx_tail;
    assign rf_set_dep  = rob_idx_tail;

endmodule

//--- tests/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

localparam logic [6:0] GRP_R      = 7'b0110011;
localparam logic [6:0] GRP_I      = 7'b0010011;
localparam logic [6:0] GRP_LOAD   = 7'b0000011;
localparam logic [6:0] GRP_STORE  = 7'b0100011;
localparam logic [6:0] GRP_BRANCH = 7'b1100011;
localparam logic [6:0] GRP_JAL    = 7'b1101111;
localparam logic [6:0] GRP_JALR   = 7'b1100111;
localparam logic [6:0] GRP_AUIPC  = 7'b0010111;
localparam logic [6:0] GRP_LUI    = 7'b0110111;

// Zero for anything that never issues
function automatic logic [6:0] opcode_group(input logic [31:0] inst);
    if (inst[1:0] != 2'b11)
        return 7'd0;
    case (inst[6:0])
        GRP_R, GRP_I, GRP_LOAD, GRP_STORE, GRP_BRANCH,
        GRP_JAL, GRP_JALR, GRP_AUIPC, GRP_LUI:
            return inst[6:0];
        default:
            return 7'd0;
    endcase
endfunction

function automatic logic [31:0] sext_i(input logic [31:0] inst);
    return 32'($signed(inst[31:20]));
endfunction

function automatic logic [31:0] branch_offset(input logic [31:0] inst);
    logic [12:0] v;
    v = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    return 32'($signed(v));
endfunction

function automatic logic [31:0] jump_offset(input logic [31:0] inst);
    logic [20:0] v;
    v = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    return 32'($signed(v));
endfunction

function automatic logic writes_rd(input logic [6:0] grp);
    return grp inside {GRP_R, GRP_I, GRP_LOAD, GRP_JAL, GRP_JALR, GRP_AUIPC, GRP_LUI};
endfunction

function automatic logic reads_rs1(input logic [6:0] grp);
    return grp inside {GRP_R, GRP_I, GRP_LOAD, GRP_STORE, GRP_BRANCH, GRP_JALR};
endfunction

function automatic logic reads_rs2(input logic [6:0] grp);
    return grp inside {GRP_R, GRP_STORE, GRP_BRANCH};
endfunction

function automatic logic goes_to_rs(input logic [6:0] grp);
    return grp inside {GRP_R, GRP_I, GRP_BRANCH};
endfunction

function automatic logic goes_to_lsb(input logic [6:0] grp);
    return grp inside {GRP_LOAD, GRP_STORE};
endfunction

// Results known at decode time
function automatic logic rob_ready_at_dispatch(input logic [6:0] grp);
    return grp inside {GRP_LUI, GRP_AUIPC, GRP_JAL, GRP_JALR, GRP_STORE};
endfunction

function automatic dec_pkg::rob_kind_e rob_kind_for(input logic [6:0] grp);
    if (grp == GRP_STORE)
        return dec_pkg::ROB_ST;
    if (grp == GRP_BRANCH)
        return dec_pkg::ROB_BR;
    return dec_pkg::ROB_RG;
endfunction

function automatic logic [31:0] rob_value_for(input logic [31:0] inst, input logic [31:0] pc);
    case (opcode_group(inst))
        GRP_LUI:           return {inst[31:12], 12'h000};
        GRP_AUIPC:         return pc + {inst[31:12], 12'h000};
        GRP_JAL, GRP_JALR: return pc + 32'd4;
        GRP_BRANCH:        return pc + branch_offset(inst);
        default:           return 32'd0;
    endcase
endfunction

function automatic logic [31:0] fetch_target(input logic [31:0] inst, input logic [31:0] pc,
                                             input logic [31:0] base);
    if (opcode_group(inst) == GRP_JALR)
        return base + sext_i(inst);  // Bit 0 kept as summed
    if (opcode_group(inst) == GRP_JAL)
        return pc + jump_offset(inst);
    return pc + 32'd4;
endfunction

function automatic logic [4:0] rs_code(input logic [31:0] inst);
    logic [6:0] grp;
    logic       alt;
    grp = opcode_group(inst);
    alt = inst[30] && (grp == GRP_R || (grp == GRP_I && inst[14:12] == 3'b101));
    return {grp == GRP_BRANCH, alt, inst[14:12]};
endfunction

function automatic logic [11:0] lsb_imm(input logic [31:0] inst);
    if (opcode_group(inst) == GRP_LOAD)
        return inst[31:20];
    return {inst[31:25], inst[11:7]};
endfunction

function automatic logic [31:0] second_operand(input logic [31:0] inst, input logic [31:0] r2);
    if (opcode_group(inst) != GRP_I)
        return r2;
    if (inst[13:12] == 2'b01)
        return {27'd0, inst[24:20]};  // Shift amount
    return sext_i(inst);
endfunction

function automatic logic [31:0] forwarded(input logic has_dep, input logic [31:0] rf_val,
                                          input logic ready, input logic [31:0] rob_val);
    if (!has_dep)
        return rf_val;
    return ready ? rob_val : 32'd0;
endfunction

`endif

//--- tests/tb_decoder.sv
`timescale 1ns/1ps

module tb_decoder;

    localparam int RUN_CYCLES  = 3000;
    localparam int CYCLE_LIMIT = 4000;  // Run plus reset, with margin

    logic clk_in;
    logic rst_n;
    logic rdy_in;
    logic rob_clear;
    logic inst_valid;
    dec_pkg::word_t inst_addr;
    dec_pkg::word_t inst_data;
    dec_pkg::word_t f_next_pc;
    logic f_ok;
    dec_pkg::reg_idx_t rf_get_idx1;
    dec_pkg::reg_idx_t rf_get_idx2;
    dec_pkg::word_t rf_get_val1;
    dec_pkg::word_t rf_get_val2;
    logic rf_has_dep1;
    logic rf_has_dep2;
    dec_pkg::rob_tag_t rf_get_dep1;
    dec_pkg::rob_tag_t rf_get_dep2;
    dec_pkg::reg_idx_t rf_set_idx;
    dec_pkg::rob_tag_t rf_set_dep;
    dec_pkg::rob_tag_t query_rob_idx1;
    dec_pkg::rob_tag_t query_rob_idx2;
    logic query_ready1;
    logic query_ready2;
    dec_pkg::word_t query_value1;
    dec_pkg::word_t query_value2;
    dec_pkg::rob_tag_t rob_idx_tail;
    logic rob_full;
    dec_pkg::rob_entry_t rob_entry;
    logic rs_full;
    logic rs_valid;
    dec_pkg::rs_type_t rs_type;
    dec_pkg::rob_tag_t rs_rob_idx;
    logic lsb_full;
    logic lsb_valid;
    dec_pkg::lsb_type_t lsb_type;
    dec_pkg::imm12_t lsb_offset;
    dec_pkg::rob_tag_t lsb_rob_idx;
    dec_pkg::operand_pair_t ops;

    `include "decode_model.svh"

    // Expected register contents after the last edge
    dec_pkg::rob_entry_t    exp_rob;
    dec_pkg::operand_pair_t exp_ops;
    logic                   exp_rs_valid;
    logic [4:0]             exp_rs_type;
    logic                   exp_lsb_valid;
    logic [3:0]             exp_lsb_type;
    logic [11:0]            exp_lsb_offset;
    logic [4:0]             exp_set_idx;
    logic [31:0]            exp_last_addr;

    logic [31:0] rng_state;
    logic [31:0] cur_addr;
    logic        accept;
    int          cycle_count = 0;

    decoder_top dut0 (.*);

    always #10 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("STATUS: FAIL");
            $fatal(1, "Timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] random_instruction();
        logic [3:0]  pick;
        logic [31:0] bits;
        logic [31:0] inst;
        bits = next_random();
        pick = bits[3:0];
        bits = next_random();
        case (pick)
            4'd0, 4'd1: inst = {1'b0, bits[30], 5'd0, bits[24:7], GRP_R};
            4'd4:       inst = {bits[31:7], GRP_LOAD};
            4'd5:       inst = {bits[31:7], GRP_STORE};
            4'd6:       inst = {bits[31:7], GRP_BRANCH};
            4'd7:       inst = {bits[31:7], GRP_JAL};
            4'd8:       inst = {bits[31:7], GRP_JALR};
            4'd9:       inst = {bits[31:7], GRP_AUIPC};
            4'd10:      inst = {bits[31:7], GRP_LUI};
            4'd11:      inst = {bits[31:7], 7'b0001111};  // FENCE, not supported
            4'd12:      inst = {bits[31:2], 1'b0, bits[0]};  // Compressed encoding
            default:    inst = {bits[31:7], GRP_I};
        endcase
        if (inst[6:0] == GRP_I && inst[13:12] == 2'b01) begin
            inst[31]    = 1'b0;
            inst[29:25] = 5'd0;
            if (!inst[14])
                inst[30] = 1'b0;  // SLLI
        end
        return inst;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "Mismatch on %s at %0t", name, $time);
        end
    endtask

    task automatic clear_expected();
        exp_rob        = '0;
        exp_ops        = '0;
        exp_rs_valid   = 1'b0;
        exp_rs_type    = '0;
        exp_lsb_valid  = 1'b0;
        exp_lsb_type   = '0;
        exp_lsb_offset = '0;
        exp_set_idx    = '0;
        exp_last_addr  = '1;
    endtask

    task automatic check_and_advance();
        logic [6:0]  grp;
        logic [31:0] r1;
        logic [31:0] r2;
        logic        p1;
        logic        p2;
        logic        ok;
        grp = opcode_group(inst_data);
        r1  = forwarded(rf_has_dep1, rf_get_val1, query_ready1, query_value1);
        r2  = forwarded(rf_has_dep2, rf_get_val2, query_ready2, query_value2);
        p1  = rf_has_dep1 && !query_ready1;
        p2  = rf_has_dep2 && !query_ready2;
        ok  = inst_valid && grp != 7'd0 && inst_addr != exp_last_addr && !rob_full
              && (!rs_full || !goes_to_rs(grp)) && (!lsb_full || !goes_to_lsb(grp))
              && !(grp == GRP_JALR && p1);

        check_eq("f_ok", 32'(ok), 32'(f_ok));
        check_eq("f_next_pc", fetch_target(inst_data, inst_addr, r1), f_next_pc);
        check_eq("query_rob_idx1", 32'(rf_get_dep1), 32'(query_rob_idx1));
        check_eq("query_rob_idx2", 32'(rf_get_dep2), 32'(query_rob_idx2));
        check_eq("rs_rob_idx", 32'(rob_idx_tail), 32'(rs_rob_idx));
        check_eq("lsb_rob_idx", 32'(rob_idx_tail), 32'(lsb_rob_idx));
        check_eq("rf_set_dep", 32'(rob_idx_tail), 32'(rf_set_dep));
        if (grp != 7'd0) begin
            check_eq("rf_get_idx1", 32'(inst_data[19:15]), 32'(rf_get_idx1));
            check_eq("rf_get_idx2", 32'(inst_data[24:20]), 32'(rf_get_idx2));
        end

        check_eq("rob_entry.valid", 32'(exp_rob.valid), 32'(rob_entry.valid));
        check_eq("rob_entry.ready", 32'(exp_rob.ready), 32'(rob_entry.ready));
        check_eq("rob_entry.kind", 32'(exp_rob.kind), 32'(rob_entry.kind));
        check_eq("rob_entry.value", exp_rob.value, rob_entry.value);
        check_eq("rob_entry.rd", 32'(exp_rob.rd), 32'(rob_entry.rd));
        check_eq("rf_set_idx", 32'(exp_set_idx), 32'(rf_set_idx));
        check_eq("rs_valid", 32'(exp_rs_valid), 32'(rs_valid));
        if (exp_rs_valid)
            check_eq("rs_type", 32'(exp_rs_type), 32'(rs_type));
        check_eq("lsb_valid", 32'(exp_lsb_valid), 32'(lsb_valid));
        if (exp_lsb_valid) begin
            check_eq("lsb_type", 32'(exp_lsb_type), 32'(lsb_type));
            check_eq("lsb_offset", 32'(exp_lsb_offset), 32'(lsb_offset));
        end
        check_eq("ops.r1", exp_ops.r1, ops.r1);
        check_eq("ops.r2", exp_ops.r2, ops.r2);
        check_eq("ops.dep1", 32'(exp_ops.dep1), 32'(ops.dep1));
        check_eq("ops.dep2", 32'(exp_ops.dep2), 32'(ops.dep2));
        check_eq("ops.has_dep1", 32'(exp_ops.has_dep1), 32'(ops.has_dep1));
        check_eq("ops.has_dep2", 32'(exp_ops.has_dep2), 32'(ops.has_dep2));

        accept = rst_n && !rob_clear && rdy_in && ok;
        if (!rst_n || rob_clear) begin
            clear_expected();
        end else if (accept) begin
            exp_rob.valid    = 1'b1;
            exp_rob.ready    = rob_ready_at_dispatch(grp);
            exp_rob.kind     = rob_kind_for(grp);
            exp_rob.value    = rob_value_for(inst_data, inst_addr);
            exp_rob.rd       = writes_rd(grp) ? inst_data[11:7] : 5'd0;
            exp_set_idx      = exp_rob.rd;
            exp_rs_valid     = goes_to_rs(grp);
            exp_rs_type      = rs_code(inst_data);
            exp_lsb_valid    = goes_to_lsb(grp);
            exp_lsb_type     = {grp == GRP_STORE, inst_data[14:12]};
            exp_lsb_offset   = lsb_imm(inst_data);
            exp_ops.r1       = r1;
            exp_ops.r2       = second_operand(inst_data, r2);
            exp_ops.dep1     = rf_get_dep1;
            exp_ops.dep2     = rf_get_dep2;
            exp_ops.has_dep1 = reads_rs1(grp) && p1;
            exp_ops.has_dep2 = reads_rs2(grp) && p2;
            exp_last_addr    = inst_addr;
        end else if (rdy_in) begin
            exp_rob.valid = 1'b0;
            exp_rs_valid  = 1'b0;
            exp_lsb_valid = 1'b0;
            exp_set_idx   = '0;
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] a;
        logic [31:0] b;
        a = next_random();
        b = next_random();
        if (accept || a[2:0] == 3'd0) begin  // Fetcher moves on, or redirects
            if (!accept || a[7:4] != 4'd0)
                cur_addr = cur_addr + 32'd4;
            inst_addr <= cur_addr;
            inst_data <= random_instruction();
        end
        inst_valid   <= a[11:8] != 4'd0;
        rob_clear    <= a[17:12] == 6'd0;
        rob_full     <= a[20:18] == 3'd0;
        rs_full      <= a[23:21] == 3'd0;
        lsb_full     <= a[26:24] == 3'd0;
        rdy_in       <= (b % 32'd10) != 32'd0;
        rst_n        <= b[31:24] != 8'd0;
        rf_has_dep1  <= b[4];
        rf_has_dep2  <= b[5];
        rf_get_dep1  <= b[8:6];
        rf_get_dep2  <= b[11:9];
        query_ready1 <= b[12];
        query_ready2 <= b[13];
        rob_idx_tail <= b[16:14];
        rf_get_val1  <= next_random();
        rf_get_val2  <= next_random();
        query_value1 <= next_random();
        query_value2 <= next_random();
    endtask

    initial begin
        rng_state    = 32'h6631;
        clk_in       = 1'b0;
        rst_n        = 1'b0;
        rdy_in       = 1'b1;
        rob_clear    = 1'b0;
        inst_valid   = 1'b0;
        cur_addr     = 32'h0000_0000;  // Address zero must issue right after reset
        inst_addr    = cur_addr;
        inst_data    = random_instruction();
        rf_get_val1  = '0;
        rf_get_val2  = '0;
        rf_has_dep1  = 1'b0;
        rf_has_dep2  = 1'b0;
        rf_get_dep1  = '0;
        rf_get_dep2  = '0;
        query_ready1 = 1'b0;
        query_ready2 = 1'b0;
        query_value1 = '0;
        query_value2 = '0;
        rob_idx_tail = '0;
        rob_full     = 1'b0;
        rs_full      = 1'b0;
        lsb_full     = 1'b0;
        accept       = 1'b0;
        clear_expected();

        repeat (2) @(posedge clk_in);
        drive_inputs();
        for (int n = 0; n < RUN_CYCLES; n++) begin
            @(negedge clk_in);
            check_and_advance();
            @(posedge clk_in);
            drive_inputs();
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- all.f
+incdir+tests
hdl/dec_pkg.sv
hdl/imm_gen.sv
hdl/op_classify.sv
hdl/operand_resolve.sv
hdl/dispatch_reg.sv
hdl/decoder_top.sv
tests/tb_decoder.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the decoder testbench with Verilator and runs it.
# The exit status is the simulator's: nonzero on any failure.

cd "$(dirname "$0")" &&
verilator --binary --timing -f all.f --top-module tb_decoder -Mdir obj_dir &&
./obj_dir/Vtb_decoder ||
exit 1
